/* adc_rx_config.svh */
/* build constants for the adc receiver
   lane layout, sample and stream widths, burst and capture sizes, frame alignment */

`ifndef ADC_RX_CONFIG_SVH
`define ADC_RX_CONFIG_SVH

// deserializer layout
`define ADC_CHANNELS 8                      // data channels
`define ADC_LANES 9                         // channels plus the frame lane
`define ADC_SAMPLE_W 10                     // bits per adc sample

// output stream
`define ADC_WORD_W 16                       // stream lane width, samples zero-extended
`define ADC_PIXEL_SIZE 2048                 // samples per pixel burst

// debug capture memory
`define ADC_CAPTURE_DEPTH 2048              // capture words, sets the address width

// frame alignment
`define ADC_FRAME_PATTERN 10'b11111_00000   // aligned frame lane word
`define ADC_SLIP_WAIT 4                     // cycles for the deserializer to apply a slip

`endif

/* adc_rx_pkg.sv */
/* adc_rx_pkg package
   vector types for raw words, samples, stream data, counters and the slip state enum */

`include "adc_rx_config.svh"

package adc_rx_pkg;

  // deserializer word, all lanes bit-interleaved
  typedef logic [`ADC_LANES*`ADC_SAMPLE_W-1:0] raw_word_t;

  typedef logic [`ADC_SAMPLE_W-1:0] sample_t;  // one adc sample

  // channel samples side by side, channel 0 in the low bits
  typedef logic [`ADC_CHANNELS*`ADC_SAMPLE_W-1:0] channel_bus_t;

  typedef logic [`ADC_CHANNELS*`ADC_WORD_W-1:0] stream_data_t;  // wide output stream

  typedef logic [$clog2(`ADC_CAPTURE_DEPTH)-1:0] capture_addr_t;  // capture memory address
  typedef logic [$clog2(`ADC_CHANNELS)-1:0] channel_sel_t;         // debug channel select
  typedef logic [$clog2(`ADC_PIXEL_SIZE)-1:0] pixel_count_t;       // burst down-counter

  // frame aligner states
  typedef enum logic [1:0] {
    st_check,   // compare frame lane to the pattern
    st_slip,    // one bitslip pulse
    st_settle   // wait for the slip to take effect
  } slip_state_t;

endpackage

/* lane_unpack.sv */
/* lane_unpack module
   undoes the deserializer bit interleave, registers channel bus and frame word */

`include "adc_rx_config.svh"

module lane_unpack (
  input  logic                     clk_adc,
  input  logic                     lresetn_adc,
  input  adc_rx_pkg::raw_word_t    raw_in,       // interleaved word from deserializer
  output adc_rx_pkg::channel_bus_t samples,      // channel 0 in low bits
  output adc_rx_pkg::sample_t      frame_word    // frame lane word
);

  import adc_rx_pkg::*;

  channel_bus_t samples_next;  // reordered channel lanes
  sample_t      frame_next;    // reordered frame lane

  // bit b of lane k sits at raw bit b*lanes + k
  always_comb begin
    for (int b = 0; b < `ADC_SAMPLE_W; b++) begin
      for (int c = 0; c < `ADC_CHANNELS; c++) begin
        samples_next[c*`ADC_SAMPLE_W + b] = raw_in[b*`ADC_LANES + c];
      end
      frame_next[b] = raw_in[b*`ADC_LANES + `ADC_LANES - 1];  // last lane is frame
    end
  end

  // single reorder stage shared by aligner, framer and capture
  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      samples    <= '0;
      frame_word <= '0;
    end else begin
      samples    <= samples_next;
      frame_word <= frame_next;
    end
  end

endmodule

/* frame_aligner.sv */
/* frame_aligner module
   frame pattern compare, spaced bitslip pulse generation and lock flag */

`include "adc_rx_config.svh"

module frame_aligner (
  input  logic                clk_adc,
  input  logic                lresetn_adc,
  input  adc_rx_pkg::sample_t frame_word,    // registered frame lane
  output logic                bitslip,       // one cycle slip request
  output logic                frame_locked   // frame lane matches pattern
);

  import adc_rx_pkg::*;

  localparam int WAIT_W = $clog2(`ADC_SLIP_WAIT + 1);  // settle counter width

  slip_state_t       state;
  slip_state_t       state_next;
  logic [WAIT_W-1:0] settle_cnt;   // remaining settle cycles
  logic              frame_match;

  assign frame_match = (frame_word == `ADC_FRAME_PATTERN);

  always_comb begin
    state_next = state;
    case (state)
      st_check: begin
        if (!frame_match) begin
          state_next = st_slip;   // misaligned, request a slip
        end
      end
      st_slip: begin
        state_next = st_settle;   // slip lasts one cycle only
      end
      st_settle: begin
        if (settle_cnt == '0) begin
          state_next = st_check;  // deserializer has applied the slip
        end
      end
      default: begin
        state_next = st_check;
      end
    endcase
  end

  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      state        <= st_check;
      settle_cnt   <= '0;
      frame_locked <= 1'b0;
    end else begin
      state        <= state_next;
      frame_locked <= frame_match;
      if (state == st_slip) begin
        settle_cnt <= WAIT_W'(`ADC_SLIP_WAIT - 1);  // settle spans slip_wait cycles
      end else if (settle_cnt != '0) begin
        settle_cnt <= settle_cnt - WAIT_W'(1);
      end
    end
  end

  // decoded from the state register, never two cycles in a row
  assign bitslip = (state == st_slip);

endmodule

/* pixel_framer.sv */
/* pixel_framer module
   go edge detect, pixel burst counter, stream valid, last, data and pixel_done */

`include "adc_rx_config.svh"

module pixel_framer (
  input  logic                     clk_adc,
  input  logic                     lresetn_adc,
  input  logic                     go,           // burst start, rising edge
  input  adc_rx_pkg::channel_bus_t samples,      // reordered channel samples
  output logic                     m_tvalid,
  output logic                     m_tlast,
  output adc_rx_pkg::stream_data_t m_tdata,
  output logic                     pixel_done    // pulse after the final beat
);

  import adc_rx_pkg::*;

  logic         go_d;       // go from previous edge
  logic         go_edge;
  logic         in_pixel;   // burst running
  logic         valid_d;    // valid from previous cycle
  pixel_count_t pixel_cnt;  // beats left after the current one
  stream_data_t data_ext;

  assign go_edge = go & ~go_d;

  // each sample zero-extended into its stream lane
  always_comb begin
    data_ext = '0;
    for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
      data_ext[ch*`ADC_WORD_W +: `ADC_SAMPLE_W] = samples[ch*`ADC_SAMPLE_W +: `ADC_SAMPLE_W];
    end
  end

  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      go_d      <= 1'b0;
      in_pixel  <= 1'b0;
      pixel_cnt <= '0;
    end else begin
      go_d <= go;
      if (go_edge) begin
        in_pixel  <= 1'b1;   // also restarts a running burst
        pixel_cnt <= pixel_count_t'(`ADC_PIXEL_SIZE - 1);
      end else if (in_pixel) begin
        if (pixel_cnt == '0) begin
          in_pixel <= 1'b0;  // last beat done
        end else begin
          pixel_cnt <= pixel_cnt - pixel_count_t'(1);
        end
      end
    end
  end

  // valid and last registered with the data so all three line up
  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
      valid_d  <= 1'b0;
    end else begin
      m_tvalid <= in_pixel;
      m_tlast  <= in_pixel & (pixel_cnt == '0) & ~go_edge;  // restart cancels last
      valid_d  <= m_tvalid;
    end
  end

  always_ff @(posedge clk_adc) begin
    m_tdata <= data_ext;  // samples of the previous raw word
  end

  assign pixel_done = valid_d & ~m_tvalid;  // falling edge of valid

endmodule

/* capture_buffer.sv */
/* capture_buffer module
   debug channel select, capture write pointer and busy flag, capture memory with readback */

`include "adc_rx_config.svh"

module capture_buffer (
  input  logic                      clk_adc,
  input  logic                      lresetn_adc,
  input  logic                      debug_go,      // capture start pulse
  input  adc_rx_pkg::channel_sel_t  capture_sel,   // held stable during capture
  input  adc_rx_pkg::channel_bus_t  samples,
  input  adc_rx_pkg::capture_addr_t rd_addr,
  output logic                      capture_busy,  // memory being written
  output adc_rx_pkg::sample_t       rd_data        // word at rd_addr, one cycle later
);

  import adc_rx_pkg::*;

  localparam int DEPTH = `ADC_CAPTURE_DEPTH;

  logic          capture_start;        // debug_go delayed one edge
  sample_t       sel_sample;           // selected channel, one stage later
  capture_addr_t wr_ptr;
  sample_t       capture_mem [DEPTH];

  // pick one channel out of the bus
  always_ff @(posedge clk_adc) begin
    sel_sample <= samples[capture_sel*`ADC_SAMPLE_W +: `ADC_SAMPLE_W];
  end

  // start is delayed so address 0 pairs with the word sampled with debug_go
  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      capture_start <= 1'b0;
      capture_busy  <= 1'b0;
      wr_ptr        <= '0;
    end else begin
      capture_start <= debug_go;
      if (capture_start) begin
        capture_busy <= 1'b1;  // new debug_go restarts at address 0
        wr_ptr       <= '0;
      end else if (capture_busy) begin
        if (wr_ptr == capture_addr_t'(DEPTH - 1)) begin
          capture_busy <= 1'b0;  // memory full
          wr_ptr       <= '0;
        end else begin
          wr_ptr <= wr_ptr + capture_addr_t'(1);
        end
      end
    end
  end

  // one write port from capture, one registered read port
  always_ff @(posedge clk_adc) begin
    if (capture_busy) begin
      capture_mem[wr_ptr] <= sel_sample;
    end
    rd_data <= capture_mem[rd_addr];
  end

endmodule

/* adc_rx_top.sv */
/* adc_rx_top module
   adc receiver top level with lane unpack, frame aligner, pixel framer and capture buffer */

module adc_rx_top (
  input  logic                      clk_adc,
  input  logic                      lresetn_adc,
  input  adc_rx_pkg::raw_word_t     raw_in,        // deserializer word
  input  logic                      go,            // pixel burst start
  input  logic                      debug_go,      // debug capture start
  input  adc_rx_pkg::channel_sel_t  capture_sel,
  input  adc_rx_pkg::capture_addr_t rd_addr,
  output logic                      bitslip,       // to deserializer
  output logic                      frame_locked,
  output logic                      m_tvalid,
  output logic                      m_tlast,
  output adc_rx_pkg::stream_data_t  m_tdata,
  output logic                      pixel_done,
  output logic                      capture_busy,
  output adc_rx_pkg::sample_t       rd_data
);

  import adc_rx_pkg::*;

  channel_bus_t samples;     // reordered channels
  sample_t      frame_word;  // reordered frame lane

  lane_unpack lane_unpack_i (
    .clk_adc     (clk_adc),
    .lresetn_adc (lresetn_adc),
    .raw_in      (raw_in),
    .samples     (samples),
    .frame_word  (frame_word)
  );

  frame_aligner frame_aligner_i (
    .clk_adc      (clk_adc),
    .lresetn_adc  (lresetn_adc),
    .frame_word   (frame_word),
    .bitslip      (bitslip),
    .frame_locked (frame_locked)
  );

  pixel_framer pixel_framer_i (
    .clk_adc     (clk_adc),
    .lresetn_adc (lresetn_adc),
    .go          (go),
    .samples     (samples),
    .m_tvalid    (m_tvalid),
    .m_tlast     (m_tlast),
    .m_tdata     (m_tdata),
    .pixel_done  (pixel_done)
  );

  capture_buffer capture_buffer_i (
    .clk_adc      (clk_adc),
    .lresetn_adc  (lresetn_adc),
    .debug_go     (debug_go),
    .capture_sel  (capture_sel),
    .samples      (samples),
    .rd_addr      (rd_addr),
    .capture_busy (capture_busy),
    .rd_data      (rd_data)
  );

endmodule

/* adc_rx_tb_assertions.sv */
/* adc_rx_tb_assertions module and its bind into adc_rx_top
   stream flag, bitslip spacing, pixel_done and reset state checks */

`include "adc_rx_config.svh"

module adc_rx_tb_assertions (
  input logic clk_adc,
  input logic lresetn_adc,
  input logic m_tvalid,
  input logic m_tlast,
  input logic pixel_done,
  input logic capture_busy,
  input logic bitslip
);

  int since_slip;  // cycles since the last bitslip, saturates at the settle time

  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      since_slip <= `ADC_SLIP_WAIT;
    end else if (bitslip) begin
      since_slip <= 0;
    end else if (since_slip < `ADC_SLIP_WAIT) begin
      since_slip <= since_slip + 1;
    end
  end

  // last only on a valid beat, then valid drops and done pulses
  last_ends_burst: assert property (
    @(posedge clk_adc) disable iff (!lresetn_adc) m_tlast |=> $fell(m_tvalid) && pixel_done
  ) else $error("m_tlast not followed by falling m_tvalid and pixel_done");

  done_after_last: assert property (
    @(posedge clk_adc) disable iff (!lresetn_adc) pixel_done |-> $past(m_tlast)
  ) else $error("pixel_done without a final beat in the previous cycle");

  // slip requests are single pulses with the settle time in between
  bitslip_spaced: assert property (
    @(posedge clk_adc) disable iff (!lresetn_adc) bitslip |-> since_slip >= `ADC_SLIP_WAIT
  ) else $error("bitslip high again before the settle time ended");

  // everything quiet while reset is held
  reset_quiet: assert property (
    @(posedge clk_adc) !lresetn_adc |-> !(m_tvalid | m_tlast | pixel_done | capture_busy | bitslip)
  ) else $error("output active during reset");

endmodule

bind adc_rx_top adc_rx_tb_assertions assertions_i (
  .clk_adc      (clk_adc),
  .lresetn_adc  (lresetn_adc),
  .m_tvalid     (m_tvalid),
  .m_tlast      (m_tlast),
  .pixel_done   (pixel_done),
  .capture_busy (capture_busy),
  .bitslip      (bitslip)
);

/* adc_rx_tb.sv */
/* adc_rx_tb testbench for adc_rx_top
   deserializer model, reference functions, stream compare, align, burst and capture tests */

`include "adc_rx_config.svh"

module adc_rx_tb;

  import adc_rx_pkg::*;

  localparam logic [31:0] SEED = 32'h4eca0b2c;
  localparam int HIST_LEN = 32768;        // raw words by edge number
  localparam int RESTART_GAP = 700;       // second go edge, cycles after the first
  localparam int ALIGN_CYCLES = 10 * (`ADC_SLIP_WAIT + 2) + 40;
  localparam int BURST_CYCLES = 2 * `ADC_PIXEL_SIZE + RESTART_GAP + 40;
  localparam int CAPTURE_CYCLES = `ADC_CAPTURE_DEPTH + 10;
  localparam int READBACK_CYCLES = `ADC_CAPTURE_DEPTH + 10;
  localparam int WATCHDOG_CYCLES =
    2 * (BURST_CYCLES + CAPTURE_CYCLES + READBACK_CYCLES) + ALIGN_CYCLES + 20;

  logic          clk_adc;
  logic          lresetn_adc;
  raw_word_t     raw_in;
  logic          go;
  logic          debug_go;
  channel_sel_t  capture_sel;
  capture_addr_t rd_addr;
  logic          bitslip;
  logic          frame_locked;
  logic          m_tvalid;
  logic          m_tlast;
  stream_data_t  m_tdata;
  logic          pixel_done;
  logic          capture_busy;
  sample_t       rd_data;

  raw_word_t raw_hist [HIST_LEN];  // word sampled at each edge
  int        edge_cnt;             // rising edges so far
  int        frame_offset;         // model frame lane rotation
  int        slip_cnt;             // bitslip pulses seen by the model
  int        errors = 0;
  string     test_name;
  int        beat_cnt;             // stream stats from the compare process
  int        last_cnt;
  int        done_cnt;
  int        burst_start_edge;
  int        last_valid_edge;
  int        last_edge;
  int        done_edge;

  adc_rx_top dut_i (
    .clk_adc      (clk_adc),
    .lresetn_adc  (lresetn_adc),
    .raw_in       (raw_in),
    .go           (go),
    .debug_go     (debug_go),
    .capture_sel  (capture_sel),
    .rd_addr      (rd_addr),
    .bitslip      (bitslip),
    .frame_locked (frame_locked),
    .m_tvalid     (m_tvalid),
    .m_tlast      (m_tlast),
    .m_tdata      (m_tdata),
    .pixel_done   (pixel_done),
    .capture_busy (capture_busy),
    .rd_data      (rd_data)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // frame lane as the deserializer delivers it at a given slip offset
  function automatic sample_t rotate_frame(input sample_t p, input int n);
    sample_t r;
    for (int b = 0; b < `ADC_SAMPLE_W; b++) begin
      r[(b + n) % `ADC_SAMPLE_W] = p[b];
    end
    return r;
  endfunction

  function automatic sample_t ref_lane(input raw_word_t raw, input int lane);
    sample_t s;
    for (int b = 0; b < `ADC_SAMPLE_W; b++) begin
      s[b] = raw[b * `ADC_LANES + lane];  // bit b of lane k at b*lanes + k
    end
    return s;
  endfunction

  function automatic stream_data_t ref_stream(input raw_word_t raw);
    stream_data_t d;
    d = '0;
    for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
      d[ch * `ADC_WORD_W +: `ADC_SAMPLE_W] = ref_lane(raw, ch);  // zero-extended lane
    end
    return d;
  endfunction

  function automatic sample_t ref_capture(input raw_word_t raw, input channel_sel_t sel);
    return ref_lane(raw, int'(sel));
  endfunction

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_stream(input string name, input stream_data_t exp, input stream_data_t act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      report_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // one go edge, optionally a second one mid-burst
  task automatic run_burst(input string name, input int restart_gap);
    int beats0;
    int lasts0;
    int dones0;
    int t0;
    int t_go;
    @(negedge clk_adc);
    test_name = name;
    beats0 = beat_cnt;
    lasts0 = last_cnt;
    dones0 = done_cnt;
    go = 1'b1;
    t0 = edge_cnt + 1;
    t_go = t0;
    repeat (3) @(negedge clk_adc);
    go = 1'b0;  // held high, still a single edge
    if (restart_gap > 0) begin
      while (edge_cnt < t0 + restart_gap - 1) @(negedge clk_adc);
      go = 1'b1;
      t_go = edge_cnt + 1;
      @(negedge clk_adc);
      go = 1'b0;
    end
    while (done_cnt == dones0) @(negedge clk_adc);
    repeat (5) @(negedge clk_adc);  // nothing may follow the done pulse
    check_count({name, " beats"}, t_go + `ADC_PIXEL_SIZE - t0, beat_cnt - beats0);
    check_count({name, " last count"}, 1, last_cnt - lasts0);
    check_count({name, " done count"}, 1, done_cnt - dones0);
    check_count({name, " first beat edge"}, t0 + 1, burst_start_edge);
    check_count({name, " last edge"}, t_go + `ADC_PIXEL_SIZE, last_edge);
    check_count({name, " final beat edge"}, t_go + `ADC_PIXEL_SIZE, last_valid_edge);
    check_count({name, " done edge"}, t_go + `ADC_PIXEL_SIZE + 1, done_edge);
  endtask

  task automatic run_capture(input string name, input channel_sel_t sel);
    int t0;
    int first_busy;
    int busy_cycles;
    @(negedge clk_adc);
    test_name = name;
    capture_sel = sel;
    @(negedge clk_adc);
    debug_go = 1'b1;
    t0 = edge_cnt + 1;
    @(negedge clk_adc);
    debug_go = 1'b0;
    check_flag({name, " busy at start"}, 1'b0, capture_busy);
    while (!capture_busy) @(negedge clk_adc);
    first_busy = edge_cnt;
    busy_cycles = 0;
    while (capture_busy) begin
      busy_cycles++;
      @(negedge clk_adc);
    end
    check_count({name, " busy start edge"}, t0 + 1, first_busy);
    check_count({name, " busy cycles"}, `ADC_CAPTURE_DEPTH, busy_cycles);
    for (int k = 0; k < `ADC_CAPTURE_DEPTH; k++) begin
      rd_addr = capture_addr_t'(k);
      @(negedge clk_adc);  // registered read port
      check_sample($sformatf("%s readback addr %0d", name, k),
                   ref_capture(raw_hist[t0 + k], sel), rd_data);
    end
  endtask

  initial begin
    clk_adc = 1'b0;
    forever #5 clk_adc = ~clk_adc;
  end

  initial begin
    edge_cnt = 0;
    forever begin
      @(posedge clk_adc);
      edge_cnt++;
    end
  end

  // deserializer model, one interleaved word per falling edge
  initial begin
    sample_t     lanes [`ADC_LANES];
    raw_word_t   raw;
    logic [31:0] rng;
    rng = SEED;
    frame_offset = 3;  // start misaligned
    slip_cnt = 0;
    raw_in = '0;
    forever begin
      @(negedge clk_adc);
      if (bitslip) begin
        slip_cnt++;
        frame_offset = (frame_offset + `ADC_SAMPLE_W - 1) % `ADC_SAMPLE_W;
      end
      for (int c = 0; c < `ADC_CHANNELS; c++) begin
        rng = xorshift32(rng);
        lanes[c] = rng[`ADC_SAMPLE_W-1:0];
      end
      lanes[`ADC_LANES-1] = rotate_frame(`ADC_FRAME_PATTERN, frame_offset);
      for (int k = 0; k < `ADC_LANES; k++) begin
        for (int b = 0; b < `ADC_SAMPLE_W; b++) begin
          raw[b * `ADC_LANES + k] = lanes[k][b];
        end
      end
      if (edge_cnt + 1 < HIST_LEN) begin
        raw_hist[edge_cnt + 1] = raw;  // sampled at the next rising edge
      end
      raw_in = raw;
    end
  end

  // stream compare, every valid beat against the previous raw word
  initial begin
    logic prev_valid;
    prev_valid = 1'b0;
    beat_cnt = 0;
    last_cnt = 0;
    done_cnt = 0;
    burst_start_edge = 0;
    last_valid_edge = 0;
    last_edge = 0;
    done_edge = 0;
    forever begin
      @(negedge clk_adc);
      if (lresetn_adc) begin
        if (m_tvalid) begin
          beat_cnt++;
          if (!prev_valid) begin
            burst_start_edge = edge_cnt;
          end
          last_valid_edge = edge_cnt;
          check_stream({test_name, " data"}, ref_stream(raw_hist[edge_cnt - 1]), m_tdata);
          if (m_tlast) begin
            last_cnt++;
            last_edge = edge_cnt;
          end
        end
        if (pixel_done) begin
          done_cnt++;
          done_edge = edge_cnt;
        end
      end
      prev_valid = m_tvalid;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_adc);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin
    channel_sel_t cap_sel;
    int           slips_at_lock;
    lresetn_adc = 1'b0;
    go = 1'b0;
    debug_go = 1'b0;
    capture_sel = '0;
    rd_addr = '0;
    test_name = "reset";
    cap_sel = channel_sel_t'(xorshift32(SEED) % `ADC_CHANNELS);
    repeat (10) @(negedge clk_adc);
    check_flag("reset m_tvalid", 1'b0, m_tvalid);
    check_flag("reset m_tlast", 1'b0, m_tlast);
    check_flag("reset pixel_done", 1'b0, pixel_done);
    check_flag("reset capture_busy", 1'b0, capture_busy);
    check_flag("reset bitslip", 1'b0, bitslip);
    lresetn_adc = 1'b1;

    test_name = "align";
    while (!frame_locked) @(negedge clk_adc);
    if (slip_cnt > 10) begin
      report_failure("frame alignment needed more than 10 bitslip pulses");
    end
    check_count("align model offset", 0, frame_offset);
    slips_at_lock = slip_cnt;
    repeat (30) @(negedge clk_adc);
    check_count("align slips after lock", slips_at_lock, slip_cnt);
    check_flag("align lock held", 1'b1, frame_locked);

    run_burst("burst", 0);
    run_burst("restart", RESTART_GAP);
    run_capture("capture", cap_sel);

    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
adc_rx_pkg.sv
lane_unpack.sv
frame_aligner.sv
pixel_framer.sv
capture_buffer.sv
adc_rx_top.sv
adc_rx_tb_assertions.sv
adc_rx_tb.sv

/* Makefile */
# Verilator build and run for the adc receiver testbench

SIM := obj_dir/Vadc_rx_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): flist.f $(wildcard *.sv *.svh)
	verilator --binary --assert -j 0 --top-module adc_rx_tb -f flist.f

# pass only when the log holds the pass line
run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	grep -q '^NO ERRORS$$' sim.log

clean:
	rm -rf obj_dir sim.log
